//--- src/dcache_geom_pkg.sv
// cache geometry and the two-view address union, imported by every cache RTL module
package dcache_geom_pkg;

  localparam int XLEN          = 32;                    // data word width
  localparam int LINE_WORDS    = 4;                     // words per line, also burst length
  localparam int IDX_BITS      = 6;                     // 64 sets
  localparam int OFF_WORD_BITS = 2;                     // word in line
  localparam int OFF_BYTE_BITS = $clog2(XLEN / 8);      // byte in word
  localparam int LINE_OFF_BITS = OFF_WORD_BITS + OFF_BYTE_BITS;
  localparam int TAG_BITS      = XLEN - IDX_BITS - LINE_OFF_BITS;
  localparam int LINE_BITS     = LINE_WORDS * XLEN;     // 128
  localparam int DEF_WAYS      = 2;

  // lookup view
  typedef struct packed {
    logic [TAG_BITS-1:0]      tag;
    logic [IDX_BITS-1:0]      idx;
    logic [OFF_WORD_BITS-1:0] word;
    logic [OFF_BYTE_BITS-1:0] boff;
  } adr_fields_t;

  // burst view, line number and offset in line
  typedef struct packed {
    logic [XLEN-LINE_OFF_BITS-1:0] line;
    logic [LINE_OFF_BITS-1:0]      off;
  } adr_line_t;

  typedef union packed {
    adr_fields_t f;
    adr_line_t   l;
  } cache_adr_u;

endpackage

//--- src/dcache_bus_pkg.sv
// access sizes, line commands and byte-enable helpers shared by the cache controller and bus side
package dcache_bus_pkg;

  localparam int BYTES_PER_WORD = 4;

  typedef enum logic [1:0] {BYTE, HWORD, WORD} acc_size_e;

  typedef enum logic [1:0] {LC_NOP, LC_FILL, LC_WRITEBACK} line_cmd_e;

  // byte enable of one access within its word
  function automatic logic [BYTES_PER_WORD-1:0] size_to_be(
    acc_size_e                           size,
    logic [$clog2(BYTES_PER_WORD)-1:0]   lsb
  );
    logic [BYTES_PER_WORD-1:0] be;
    case (size)
      BYTE:    be = 4'b0001;
      HWORD:   be = 4'b0011;
      default: be = 4'b1111;
    endcase
    return be << lsb;
  endfunction

  // take enabled bytes from new_w, the rest from old_w
  function automatic logic [8*BYTES_PER_WORD-1:0] be_merge(
    logic [BYTES_PER_WORD-1:0]   be,
    logic [8*BYTES_PER_WORD-1:0] old_w,
    logic [8*BYTES_PER_WORD-1:0] new_w
  );
    logic [8*BYTES_PER_WORD-1:0] res;
    res = old_w;
    for (int i = 0; i < BYTES_PER_WORD; i++)
      if (be[i])
        res[8*i +: 8] = new_w[8*i +: 8];
    return res;
  endfunction

endpackage

//--- src/dcache_arrays.sv
// tag, valid, dirty and data storage of all ways with hit compare and random victim choice
`timescale 1ns/100ps

module dcache_arrays #(
  parameter int WAYS = dcache_geom_pkg::DEF_WAYS
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  dcache_geom_pkg::cache_adr_u           rd_adr_i,
  input  logic                                  wr_en_i,
  input  logic [WAYS-1:0]                       wr_way_i,
  input  logic [dcache_geom_pkg::LINE_BITS-1:0] wr_line_i,
  input  logic [dcache_geom_pkg::LINE_BITS/8-1:0] wr_be_i,
  input  logic                                  wr_dirty_i,
  output logic                                  hit_o,
  output logic [WAYS-1:0]                       hit_way_o,
  output logic [dcache_geom_pkg::LINE_BITS-1:0] rd_line_o,
  output logic [WAYS-1:0]                       victim_way_o,
  output logic                                  victim_dirty_o,
  output logic [dcache_geom_pkg::TAG_BITS-1:0]  victim_tag_o,
  output logic [dcache_geom_pkg::LINE_BITS-1:0] victim_line_o
);
  import dcache_geom_pkg::*;

  localparam int SETS  = 1 << IDX_BITS;
  localparam int VBITS = (WAYS > 1) ? $clog2(WAYS) : 1;   // lfsr bits for way select

  logic [TAG_BITS-1:0]       tag_q  [WAYS][SETS];
  logic [LINE_BITS-1:0]      data_q [WAYS][SETS];
  logic [WAYS-1:0][SETS-1:0] valid_q;
  logic [WAYS-1:0][SETS-1:0] dirty_q;
  cache_adr_u                adr_q;                        // registered lookup address
  logic [19:0]               lfsr_q;
  logic [WAYS-1:0]           way_hit;

  always_ff @(posedge clk_i)
    adr_q <= rd_adr_i;                                     // 1-cycle array read

  // ----------------------------------------
  // write port, always at the held index
  always_ff @(posedge clk_i)
  begin
    for (int w = 0; w < WAYS; w++)
    begin
      if (wr_en_i && wr_way_i[w])
      begin
        tag_q[w][adr_q.f.idx] <= adr_q.f.tag;
        for (int b = 0; b < LINE_BITS/8; b++)
          if (wr_be_i[b])
            data_q[w][adr_q.f.idx][8*b +: 8] <= wr_line_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      for (int w = 0; w < WAYS; w++)
      begin
        if (wr_en_i && wr_way_i[w])
        begin
          valid_q[w][adr_q.f.idx] <= 1'b1;
          dirty_q[w][adr_q.f.idx] <= wr_dirty_i;       // refill of a read comes back clean
        end
      end
    end
  end

  // random replacement, frozen while the held lookup misses so the victim stays put
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      lfsr_q <= '0;
    else if (hit_o)
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ~^ lfsr_q[16]};
  end

  // ----------------------------------------
  // compare and victim mux
  always_comb
  begin
    rd_line_o      = '0;
    victim_dirty_o = 1'b0;
    victim_tag_o   = '0;
    victim_line_o  = '0;
    for (int w = 0; w < WAYS; w++)
    begin
      way_hit[w]      = valid_q[w][adr_q.f.idx] && (tag_q[w][adr_q.f.idx] == adr_q.f.tag);
      victim_way_o[w] = (WAYS == 1) || (lfsr_q[VBITS-1:0] == VBITS'(w));
      if (way_hit[w])
        rd_line_o = rd_line_o | data_q[w][adr_q.f.idx];   // and-or mux, one hot
      if (victim_way_o[w])
      begin
        victim_dirty_o = valid_q[w][adr_q.f.idx] && dirty_q[w][adr_q.f.idx];
        victim_tag_o   = tag_q[w][adr_q.f.idx];
        victim_line_o  = data_q[w][adr_q.f.idx];
      end
    end
  end

  assign hit_o     = |way_hit;
  assign hit_way_o = way_hit;

endmodule

//--- src/dcache_ctrl.sv
// request register and miss FSM; issues line commands and array writes, answers the CPU
`timescale 1ns/100ps

module dcache_ctrl #(
  parameter int WAYS = dcache_geom_pkg::DEF_WAYS
) (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    mem_req_i,
  input  logic                                    mem_we_i,
  input  logic [dcache_geom_pkg::XLEN-1:0]        mem_adr_i,
  input  dcache_bus_pkg::acc_size_e               mem_size_i,
  input  logic [dcache_geom_pkg::XLEN-1:0]        mem_d_i,
  output logic [dcache_geom_pkg::XLEN-1:0]        mem_q_o,
  output logic                                    mem_ack_o,
  input  logic                                    hit_i,
  input  logic [WAYS-1:0]                         hit_way_i,
  input  logic [dcache_geom_pkg::LINE_BITS-1:0]   rd_line_i,
  input  logic [WAYS-1:0]                         victim_way_i,
  input  logic                                    victim_dirty_i,
  input  logic [dcache_geom_pkg::TAG_BITS-1:0]    victim_tag_i,
  input  logic [dcache_geom_pkg::LINE_BITS-1:0]   fill_line_i,
  input  logic                                    line_done_i,
  output dcache_geom_pkg::cache_adr_u             rd_adr_o,
  output logic                                    wr_en_o,
  output logic [WAYS-1:0]                         wr_way_o,
  output logic [dcache_geom_pkg::LINE_BITS-1:0]   wr_line_o,
  output logic [dcache_geom_pkg::LINE_BITS/8-1:0] wr_be_o,
  output logic                                    wr_dirty_o,
  output logic                                    victim_load_o,
  output dcache_bus_pkg::line_cmd_e               line_cmd_o,
  output logic [dcache_geom_pkg::XLEN-1:0]        line_adr_o
);
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;

  localparam logic [2:0] S_IDLE      = 3'd0;
  localparam logic [2:0] S_LOOKUP    = 3'd1;
  localparam logic [2:0] S_WRITEBACK = 3'd2;
  localparam logic [2:0] S_FILL      = 3'd3;
  localparam logic [2:0] S_REFILL    = 3'd4;

  logic [2:0]                state_q;
  cache_adr_u                req_in;
  cache_adr_u                req_adr_q;
  cache_adr_u                wb_adr;
  cache_adr_u                fill_adr;
  logic                      req_we_q;
  logic [BYTES_PER_WORD-1:0] req_be_q;
  logic [XLEN-1:0]           req_d_q;
  logic [XLEN-1:0]           fill_word;

  assign req_in   = mem_adr_i;
  assign rd_adr_o = mem_req_i ? req_in : req_adr_q;   // new index straight to the arrays

  // request register, held for the whole access
  always_ff @(posedge clk_i)
  begin
    if (mem_req_i)
    begin
      req_adr_q <= req_in;
      req_we_q  <= mem_we_i;
      req_be_q  <= size_to_be(mem_size_i, req_in.f.boff);
      req_d_q   <= mem_d_i;
    end
  end

  // ----------------------------------------
  // miss FSM
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      state_q <= S_IDLE;
    else
    begin
      case (state_q)
        S_IDLE:
          if (mem_req_i)
            state_q <= S_LOOKUP;
        S_LOOKUP:
          if (hit_i)
            state_q <= S_IDLE;
          else if (victim_dirty_i)
            state_q <= S_WRITEBACK;                  // evict first
          else
            state_q <= S_FILL;
        S_WRITEBACK:
          if (line_done_i)
            state_q <= S_FILL;
        S_FILL:
          if (line_done_i)
            state_q <= S_REFILL;
        S_REFILL:
          state_q <= S_LOOKUP;                       // re-read, now hits
        default:
          state_q <= S_IDLE;
      endcase
    end
  end

  // answer one cycle after the compare
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      mem_ack_o <= 1'b0;
    else
      mem_ack_o <= (state_q == S_LOOKUP) && hit_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == S_LOOKUP && hit_i)
      mem_q_o <= rd_line_i[req_adr_q.f.word*XLEN +: XLEN];
  end

  // ----------------------------------------
  // array write: write hit or refill
  assign fill_word = req_we_q ?
                     be_merge(req_be_q, fill_line_i[req_adr_q.f.word*XLEN +: XLEN], req_d_q) :
                     fill_line_i[req_adr_q.f.word*XLEN +: XLEN];

  always_comb
  begin
    wr_en_o    = (state_q == S_LOOKUP) && hit_i && req_we_q;
    wr_way_o   = hit_way_i;
    wr_line_o  = {LINE_WORDS{req_d_q}};               // word copied, byte enables pick
    wr_be_o    = {{(LINE_BITS/8-BYTES_PER_WORD){1'b0}}, req_be_q}
                 << (req_adr_q.f.word * BYTES_PER_WORD);
    wr_dirty_o = req_we_q;
    if (state_q == S_REFILL)
    begin
      wr_en_o   = 1'b1;
      wr_way_o  = victim_way_i;
      wr_line_o = fill_line_i;
      wr_line_o[req_adr_q.f.word*XLEN +: XLEN] = fill_word;
      wr_be_o   = '1;                                 // whole line
    end
  end

  // ----------------------------------------
  // line commands toward the burst engine
  always_comb
  begin
    wb_adr        = req_adr_q;
    wb_adr.f.tag  = victim_tag_i;                     // victim lives at same index
    wb_adr.f.word = '0;
    wb_adr.f.boff = '0;
    fill_adr      = req_adr_q;
    fill_adr.l.off = '0;                              // line aligned
    case (state_q)
      S_WRITEBACK:
      begin
        line_cmd_o = LC_WRITEBACK;
        line_adr_o = wb_adr;
      end
      S_FILL:
      begin
        line_cmd_o = LC_FILL;
        line_adr_o = fill_adr;
      end
      default:
      begin
        line_cmd_o = LC_NOP;
        line_adr_o = fill_adr;
      end
    endcase
  end

  assign victim_load_o = (state_q == S_LOOKUP) && !hit_i && victim_dirty_i;

endmodule

//--- src/dcache_line_buffer.sv
// one-line buffer between the arrays and the bus, victim out word by word, fill beats in by index
`timescale 1ns/100ps

module dcache_line_buffer (
  input  logic                                     clk_i,
  input  logic                                     victim_load_i,
  input  logic [dcache_geom_pkg::LINE_BITS-1:0]    victim_line_i,
  input  logic                                     beat_wr_i,
  input  logic                                     beat_rd_i,
  input  logic [dcache_geom_pkg::OFF_WORD_BITS-1:0] beat_idx_i,
  input  logic [dcache_geom_pkg::XLEN-1:0]         beat_d_i,
  output logic [dcache_geom_pkg::XLEN-1:0]         word_o,
  output logic [dcache_geom_pkg::LINE_BITS-1:0]    line_o
);
  import dcache_geom_pkg::*;

  logic [LINE_BITS-1:0] line_q;

  always_ff @(posedge clk_i)
  begin
    if (victim_load_i)
      line_q <= victim_line_i;                       // dirty victim for write-back
    else if (beat_rd_i)
      line_q <= line_q >> XLEN;                      // next word down after each ack
    else if (beat_wr_i)
      line_q[beat_idx_i*XLEN +: XLEN] <= beat_d_i;   // fill beat at its word
  end

  assign word_o = line_q[XLEN-1:0];                  // current write-back word
  assign line_o = line_q;

endmodule

//--- src/dcache_burst.sv
// bus FSM that runs one line burst per command and steers beats into the line buffer
`timescale 1ns/100ps

module dcache_burst (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  dcache_bus_pkg::line_cmd_e                 line_cmd_i,
  input  logic [dcache_geom_pkg::XLEN-1:0]          line_adr_i,
  input  logic [dcache_geom_pkg::XLEN-1:0]          word_i,
  input  logic                                      bus_stb_ack_i,
  input  logic                                      bus_ack_i,
  output logic                                      bus_stb_o,
  output logic                                      bus_we_o,
  output logic [dcache_geom_pkg::XLEN-1:0]          bus_adr_o,
  output logic [dcache_geom_pkg::XLEN-1:0]          bus_d_o,
  output logic                                      beat_wr_o,
  output logic                                      beat_rd_o,
  output logic [dcache_geom_pkg::OFF_WORD_BITS-1:0] beat_idx_o,
  output logic                                      line_done_o
);
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;

  localparam logic [1:0] B_IDLE    = 2'd0;
  localparam logic [1:0] B_REQUEST = 2'd1;
  localparam logic [1:0] B_BURST   = 2'd2;

  logic [1:0]               state_q;
  logic [OFF_WORD_BITS-1:0] cnt_q;                    // beat counter
  logic                     we_q;
  logic [XLEN-1:0]          adr_q;
  logic                     start;
  logic                     last_beat;

  // line_done_o blocks a restart on the stale command in the done cycle
  assign start     = (state_q == B_IDLE) && (line_cmd_i != LC_NOP) && !line_done_o;
  assign last_beat = (state_q == B_BURST) && bus_ack_i &&
                     (cnt_q == OFF_WORD_BITS'(LINE_WORDS - 1));

  // ----------------------------------------
  // FSM
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q     <= B_IDLE;
      cnt_q       <= '0;
      line_done_o <= 1'b0;
    end
    else
    begin
      line_done_o <= last_beat;                      // one cycle after the last ack
      case (state_q)
        B_IDLE:
          if (start)
            state_q <= B_REQUEST;
        B_REQUEST:
          if (bus_stb_ack_i)
          begin
            state_q <= B_BURST;
            cnt_q   <= '0;
          end
        B_BURST:
          if (bus_ack_i)
          begin
            cnt_q <= cnt_q + 1'b1;
            if (last_beat)
              state_q <= B_IDLE;
          end
        default:
          state_q <= B_IDLE;
      endcase
    end
  end

  // command latched when the burst starts
  always_ff @(posedge clk_i)
  begin
    if (start)
    begin
      adr_q <= line_adr_i;
      we_q  <= (line_cmd_i == LC_WRITEBACK);
    end
  end

  assign bus_stb_o  = (state_q == B_REQUEST);         // held until stb ack
  assign bus_we_o   = we_q;
  assign bus_adr_o  = adr_q;
  assign bus_d_o    = word_i;                          // buffer shifts after each ack
  assign beat_wr_o  = (state_q == B_BURST) && bus_ack_i && !we_q;
  assign beat_rd_o  = (state_q == B_BURST) && bus_ack_i && we_q;
  assign beat_idx_o = cnt_q;

endmodule

//--- src/dcache_top.sv
// write-back data cache top level, CPU request port on one side and burst bus on the other
`timescale 1ns/100ps

module dcache_top #(
  parameter int WAYS = dcache_geom_pkg::DEF_WAYS
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             mem_req_i,
  input  logic                             mem_we_i,
  input  logic [dcache_geom_pkg::XLEN-1:0] mem_adr_i,
  input  dcache_bus_pkg::acc_size_e        mem_size_i,
  input  logic [dcache_geom_pkg::XLEN-1:0] mem_d_i,
  output logic [dcache_geom_pkg::XLEN-1:0] mem_q_o,
  output logic                             mem_ack_o,
  output logic                             bus_stb_o,
  input  logic                             bus_stb_ack_i,
  output logic                             bus_we_o,
  output logic [dcache_geom_pkg::XLEN-1:0] bus_adr_o,
  output logic [dcache_geom_pkg::XLEN-1:0] bus_d_o,
  input  logic [dcache_geom_pkg::XLEN-1:0] bus_q_i,
  input  logic                             bus_ack_i
);
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;

  // ----------------------------------------
  // ctrl <-> arrays
  cache_adr_u             rd_adr;
  logic                   hit, wr_en, wr_dirty, victim_dirty;
  logic [WAYS-1:0]        hit_way, wr_way, victim_way;
  logic [LINE_BITS-1:0]   rd_line, wr_line, victim_line, fill_line;
  logic [LINE_BITS/8-1:0] wr_be;
  logic [TAG_BITS-1:0]    victim_tag;
  // command path and beats
  logic                   victim_load, line_done, beat_wr, beat_rd;
  line_cmd_e              line_cmd;
  logic [XLEN-1:0]        line_adr, buf_word;
  logic [OFF_WORD_BITS-1:0] beat_idx;

  dcache_ctrl #(.WAYS(WAYS)) ctrl_i (
    .clk_i(clk_i), .rst_ni(rst_ni),
    .mem_req_i(mem_req_i), .mem_we_i(mem_we_i), .mem_adr_i(mem_adr_i),
    .mem_size_i(mem_size_i), .mem_d_i(mem_d_i), .mem_q_o(mem_q_o), .mem_ack_o(mem_ack_o),
    .hit_i(hit), .hit_way_i(hit_way), .rd_line_i(rd_line),
    .victim_way_i(victim_way), .victim_dirty_i(victim_dirty), .victim_tag_i(victim_tag),
    .fill_line_i(fill_line), .line_done_i(line_done),
    .rd_adr_o(rd_adr), .wr_en_o(wr_en), .wr_way_o(wr_way), .wr_line_o(wr_line),
    .wr_be_o(wr_be), .wr_dirty_o(wr_dirty), .victim_load_o(victim_load),
    .line_cmd_o(line_cmd), .line_adr_o(line_adr)
  );

  dcache_arrays #(.WAYS(WAYS)) arrays_i (
    .clk_i(clk_i), .rst_ni(rst_ni), .rd_adr_i(rd_adr),
    .wr_en_i(wr_en), .wr_way_i(wr_way), .wr_line_i(wr_line), .wr_be_i(wr_be),
    .wr_dirty_i(wr_dirty), .hit_o(hit), .hit_way_o(hit_way), .rd_line_o(rd_line),
    .victim_way_o(victim_way), .victim_dirty_o(victim_dirty),
    .victim_tag_o(victim_tag), .victim_line_o(victim_line)
  );

  dcache_line_buffer line_buf_i (
    .clk_i(clk_i), .victim_load_i(victim_load), .victim_line_i(victim_line),
    .beat_wr_i(beat_wr), .beat_rd_i(beat_rd), .beat_idx_i(beat_idx), .beat_d_i(bus_q_i),
    .word_o(buf_word), .line_o(fill_line)
  );

  dcache_burst burst_i (
    .clk_i(clk_i), .rst_ni(rst_ni), .line_cmd_i(line_cmd), .line_adr_i(line_adr),
    .word_i(buf_word), .bus_stb_ack_i(bus_stb_ack_i), .bus_ack_i(bus_ack_i),
    .bus_stb_o(bus_stb_o), .bus_we_o(bus_we_o), .bus_adr_o(bus_adr_o), .bus_d_o(bus_d_o),
    .beat_wr_o(beat_wr), .beat_rd_o(beat_rd), .beat_idx_o(beat_idx),
    .line_done_o(line_done)
  );

endmodule

//--- test/tb_mem_model.sv
// burst memory responder for the cache bus with random stall cycles and its own backing store
`timescale 1ns/100ps

module tb_mem_model (
  input  logic        clk_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] d_i,
  output logic        stb_ack_o,
  output logic        ack_o,
  output logic [31:0] q_o
);

  logic [31:0] store [int];                        // word address -> word
  integer      seed;
  int          stall;                              // idle cycles before the next response
  int          beat;
  logic        active;                             // burst accepted, beats pending
  logic        we_q;
  logic [31:0] adr_q;

  // content of a never written word, a hash of the whole address
  function automatic logic [31:0] init_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic [31:0] peek(input logic [31:0] a);
    if (store.exists(int'(a >> 2)))
      return store[int'(a >> 2)];
    return init_word({a[31:2], 2'b00});
  endfunction

  initial
  begin
    seed      = 32'ha0d809cf;
    stb_ack_o = 1'b0;
    ack_o     = 1'b0;
    q_o       = '0;
    stall     = 0;
    beat      = 0;
    active    = 1'b0;
    we_q      = 1'b0;
    adr_q     = '0;
  end

  // ----------------------------------------
  // responses change on the falling edge only
  always @(negedge clk_i)
  begin
    stb_ack_o <= 1'b0;
    ack_o     <= 1'b0;
    if (stall > 0)
      stall <= stall - 1;                          // back-pressure
    else if (active)
    begin
      ack_o <= 1'b1;
      if (we_q)
        store[int'(adr_q >> 2) + beat] = d_i;      // current write-back word
      else
        q_o <= peek(adr_q + 32'(4 * beat));
      beat  <= beat + 1;
      if (beat == 3)
        active <= 1'b0;                            // last of four beats
      stall <= {$random(seed)} % 4;
    end
    else if (stb_i && !stb_ack_o)
    begin
      stb_ack_o <= 1'b1;                           // accept the line request
      active    <= 1'b1;
      beat      <= 0;
      adr_q     <= adr_i;
      we_q      <= we_i;
      stall     <= {$random(seed)} % 4;
    end
  end

endmodule

//--- test/dcache_assertions.sv
// concurrent checks on the cache bus ports, bound into the cache top level
`timescale 1ns/100ps

module dcache_assertions (
  input logic        clk_i,
  input logic        rst_ni,
  input logic        bus_stb_o,
  input logic        bus_stb_ack_i,
  input logic        bus_ack_i,
  input logic [31:0] bus_adr_o
);

  int open_beats;                                  // beats still owed by the memory

  always @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      open_beats <= 0;
    else if (bus_stb_ack_i)
      open_beats <= 4;
    else if (bus_ack_i)
      open_beats <= open_beats - 1;
  end

  // strobe stays up until accepted
  stb_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_stb_o && !bus_stb_ack_i |=> bus_stb_o)
    else $error("strobe dropped before its acknowledge");

  stb_ack_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_stb_ack_i |-> bus_stb_o)
    else $error("strobe acknowledge without a strobe");

  beat_ack_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_ack_i |-> open_beats != 0)
    else $error("beat acknowledge without an open burst");

  adr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_stb_o |-> bus_adr_o[3:0] == 4'h0)
    else $error("burst address not line aligned");

endmodule

bind dcache_top dcache_assertions assertions_i (
  .clk_i(clk_i), .rst_ni(rst_ni), .bus_stb_o(bus_stb_o),
  .bus_stb_ack_i(bus_stb_ack_i), .bus_ack_i(bus_ack_i), .bus_adr_o(bus_adr_o)
);

//--- test/tb_dcache.sv
// testbench of the data cache: random requests against a flat byte model, bus burst monitor
`timescale 1ns/100ps

module tb_dcache;
  import dcache_geom_pkg::*;
  import dcache_bus_pkg::*;

  localparam int N_RAND    = 400;
  localparam int N_SWEEP   = 64;
  localparam int WORST_CYC = 64;                   // two bursts with max stalls, plus lookups
  localparam int LIMIT     = (N_RAND + N_SWEEP) * WORST_CYC + 200;

  logic        clk, rst_n;
  logic        mem_req, mem_we, mem_ack;
  logic [31:0] mem_adr, mem_d, mem_q;
  acc_size_e   mem_size;
  logic        bus_stb, bus_stb_ack, bus_we, bus_ack;
  logic [31:0] bus_adr, bus_d, bus_q;

  integer      seed;
  int          errors, cycles;
  logic [7:0]  ref_mem [int];                      // flat byte model
  bit          dirty_ref [int];                    // line written since its last write-back
  int          cur_line;
  bit          fill_ok;
  // burst monitor state
  bit          in_burst, b_we;
  int          b_cnt;
  logic [31:0] b_adr, d_last;

  dcache_top #(.WAYS(DEF_WAYS)) dut_i (
    .clk_i(clk), .rst_ni(rst_n), .mem_req_i(mem_req), .mem_we_i(mem_we),
    .mem_adr_i(mem_adr), .mem_size_i(mem_size), .mem_d_i(mem_d), .mem_q_o(mem_q),
    .mem_ack_o(mem_ack), .bus_stb_o(bus_stb), .bus_stb_ack_i(bus_stb_ack),
    .bus_we_o(bus_we), .bus_adr_o(bus_adr), .bus_d_o(bus_d), .bus_q_i(bus_q),
    .bus_ack_i(bus_ack)
  );

  tb_mem_model mem_i (
    .clk_i(clk), .stb_i(bus_stb), .we_i(bus_we), .adr_i(bus_adr), .d_i(bus_d),
    .stb_ack_o(bus_stb_ack), .ack_o(bus_ack), .q_o(bus_q)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // reference model
  function automatic logic [31:0] ref_word(input logic [31:0] a);
    logic [31:0] w;
    w = mem_i.init_word({a[31:2], 2'b00});         // unwritten bytes keep memory content
    for (int i = 0; i < 4; i++)
      if (ref_mem.exists(int'({a[31:2], 2'b00}) + i))
        w[8*i +: 8] = ref_mem[int'({a[31:2], 2'b00}) + i];
    return w;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  // one CPU access, waits for the acknowledge
  task automatic do_req(input bit we, input logic [31:0] adr, input int sz,
                        input logic [31:0] d, input bit expect_hit);
    int lat;
    int nb;
    @(negedge clk);
    mem_req  = 1'b1;
    mem_we   = we;
    mem_adr  = adr;
    mem_size = acc_size_e'(sz);
    mem_d    = d;
    fill_ok  = 1'b0;
    cur_line = int'(adr >> 4);
    nb       = (sz == 0) ? 1 : (sz == 1) ? 2 : 4;
    if (we)
    begin
      for (int i = 0; i < nb; i++)
        ref_mem[int'(adr) + i] = d[8*(adr[1:0]+i) +: 8];   // lanes by address
      dirty_ref[cur_line] = 1'b1;
    end
    @(negedge clk);
    mem_req = 1'b0;
    lat     = 1;
    while (!mem_ack)
    begin
      @(negedge clk);
      lat++;
    end
    if (!we)
      check("mem_q_o", mem_q, ref_word(adr));
    if (expect_hit)
      check("hit latency", 32'(lat), 32'd2);
    if (lat != 2 && !fill_ok)
    begin
      errors++;
      $display("miss at %h answered without a fill burst of its line", adr);
    end
  endtask

  // ----------------------------------------
  // bus monitor, samples on the falling edge what the last rising edge took
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (bus_stb && in_burst)
      begin
        errors++;
        $display("strobe raised again after only %0d beats", b_cnt);
      end
      if (bus_stb_ack)
      begin
        if (bus_adr[3:0] != 4'h0)
        begin
          errors++;
          $display("burst address %h is not line aligned", bus_adr);
        end
        in_burst = 1'b1;
        b_we     = bus_we;
        b_adr    = bus_adr;
        b_cnt    = 0;
      end
      if (bus_ack && in_burst)
      begin
        if (b_we)
        begin
          check("bus_d_o", d_last, ref_word(b_adr + 32'(4 * b_cnt)));
          dirty_ref[int'(b_adr >> 4)] = 1'b0;
        end
        b_cnt++;
        if (b_cnt == LINE_WORDS)
        begin
          in_burst = 1'b0;
          if (!b_we && int'(b_adr >> 4) == cur_line)
            fill_ok = 1'b1;
        end
      end
    end
    d_last = bus_d;                                // word the model took at this edge
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("timeout after %0d cycles, a request or burst never finished", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // ----------------------------------------
  // stimulus
  initial
  begin
    logic [31:0] adr, last_adr;
    int          sz, boff, tag, idx;
    bit          we, same;
    seed     = 32'ha0d809cf;
    errors   = 0;
    cycles   = 0;
    in_burst = 1'b0;
    b_cnt    = 0;
    fill_ok  = 1'b0;
    cur_line = -1;
    last_adr = '0;
    rst_n    = 1'b0;
    mem_req  = 1'b0;
    mem_we   = 1'b0;
    mem_adr  = '0;
    mem_size = BYTE;
    mem_d    = '0;
    repeat (10)
    begin
      @(negedge clk);
      check("mem_ack_o", 32'(mem_ack), 32'd0);
      check("bus_stb_o", 32'(bus_stb), 32'd0);
    end
    rst_n = 1'b1;
    repeat (3)
    begin
      @(negedge clk);
      check("mem_ack_o", 32'(mem_ack), 32'd0);
      check("bus_stb_o", 32'(bus_stb), 32'd0);
    end
    for (int n = 0; n < N_RAND; n++)
    begin
      same = (n > 0) && ({$random(seed)} % 4 == 0);   // reuse the line just answered
      tag  = {$random(seed)} % 4;
      idx  = ({$random(seed)} % 2) ? 37 : 5;          // two sets only
      sz   = {$random(seed)} % 3;
      boff = (sz == 0) ? {$random(seed)} % 4 : (sz == 1) ? 2 * ({$random(seed)} % 2) : 0;
      we   = {$random(seed)} % 2;
      adr  = 32'h0001_0000 | 32'(tag << 10) | 32'(idx << 4)
             | 32'(({$random(seed)} % 4) << 2) | 32'(boff);
      if (same)
        adr[31:4] = last_adr[31:4];
      do_req(we, adr, sz, $random(seed), same);
      last_adr = adr;
    end
    // conflicting sweep pushes the pool lines out
    for (int t = 0; t < N_SWEEP; t++)
      do_req(1'b0, 32'h0001_0000 | 32'((8 + t / 2) << 10) | ((t % 2) ? 32'h250 : 32'h50),
             2, '0, 1'b0);
    for (int tg = 0; tg < 4; tg++)
      for (int s = 0; s < 2; s++)
      begin
        adr = 32'h0001_0000 | 32'(tg << 10) | (s ? 32'h250 : 32'h50);
        if (!(dirty_ref.exists(int'(adr >> 4)) && dirty_ref[int'(adr >> 4)]))
          for (int w = 0; w < LINE_WORDS; w++)
            check("backing store", mem_i.peek(adr + 32'(4 * w)), ref_word(adr + 32'(4 * w)));
      end
    $display("errors: %0d  cycles: %0d", errors, cycles);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- filelist.f
src/dcache_geom_pkg.sv
src/dcache_bus_pkg.sv
src/dcache_arrays.sv
src/dcache_ctrl.sv
src/dcache_line_buffer.sv
src/dcache_burst.sv
src/dcache_top.sv
test/tb_mem_model.sv
test/dcache_assertions.sv
test/tb_dcache.sv

//--- Makefile
# Verilator build for the data cache testbench

TOP := tb_dcache
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

obj_dir/V$(TOP): filelist.f $(shell cat filelist.f)
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
